//--- rtl/rf_store_config.svh
`ifndef RF_STORE_CONFIG_SVH
`define RF_STORE_CONFIG_SVH

// ------------------------------------------------------------
// Register file geometry
// ------------------------------------------------------------
`define RF_DEPTH     512
`define RF_ADDR_W    9
`define RF_DATA_W    14

// ------------------------------------------------------------
// Command opcodes; the fourth encoding is reserved as illegal
// ------------------------------------------------------------
`define RF_OP_W      2
`define RF_OP_WRITE  2'd0
`define RF_OP_READ   2'd1
`define RF_OP_ADD    2'd2

// Credit pools, the command pool also sets the queue depth
`define CMD_CREDITS  4
`define RES_CREDITS  2
`define CRED_W       3

`endif

//--- rtl/rf_store_pkg.sv
`include "rf_store_config.svh"

package rf_store_pkg;

    // Index into the 512-entry register file
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    // Stored word, also the width of every result word
    typedef logic [`RF_DATA_W-1:0] rf_data_t;

    // Command opcode as sent by the host
    typedef logic [`RF_OP_W-1:0] rf_op_t;

    // Holds either credit pool, the command pool needs 0 to 4
    typedef logic [`CRED_W-1:0] cred_cnt_t;

    // Execute FSM
    // IDLE picks up the head command, READ_WAIT sees the array output,
    // WRITE_BACK stores the sum of an ADD
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        READ_WAIT  = 2'd1,
        WRITE_BACK = 2'd2
    } exec_state_e;

endpackage

//--- rtl/rf_512x14.sv
`timescale 1ns/1ps
`include "rf_store_config.svh"

module rf_512x14 import rf_store_pkg::*; (
     input  logic     clk

    // Write port
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    // Read port, data comes back one cycle after re
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_data_t rdata
);

    // ------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------

    // Contents come up unknown after power on, as in the hard macro
    rf_data_t mem [`RF_DEPTH];

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------
    // Registered read port
    // ------------------------------------------------------------

    // The output latch keeps its last word while re is low
    // A read in the cycle after a write to the same entry sees the new word
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- rtl/rf_cmd_decode.sv
`timescale 1ns/1ps
`include "rf_store_config.svh"

module rf_cmd_decode import rf_store_pkg::*; (
     input  logic     clk
    ,input  logic     rst_n

    // Credited command input from the host
    ,input  logic     cmd_valid
    ,input  rf_op_t   cmd_op
    ,input  rf_addr_t cmd_addr
    ,input  rf_data_t cmd_data
    ,output logic     cmd_credit

    // Decoded head of queue towards execute
    ,output logic     dec_valid
    ,output logic     dec_write
    ,output logic     dec_read
    ,output logic     dec_add
    ,output logic     dec_illegal
    ,output rf_addr_t dec_addr
    ,output rf_data_t dec_data
    ,input  logic     exec_pop
);

    localparam int PTR_W = $clog2(`CMD_CREDITS);

    // ------------------------------------------------------------
    // Queue storage and pointers
    // ------------------------------------------------------------

    rf_op_t            q_op   [`CMD_CREDITS];
    rf_addr_t          q_addr [`CMD_CREDITS];
    rf_data_t          q_data [`CMD_CREDITS];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    cred_cnt_t         q_cnt;
    rf_op_t            head_op;

    // Entry payload is written without reset, the count tells what is live
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            q_op[wr_ptr]   <= cmd_op;
            q_addr[wr_ptr] <= cmd_addr;
            q_data[wr_ptr] <= cmd_data;
        end
    end

    // Pointers wrap at the queue depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CMD_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (exec_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CMD_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, a push and a pop in one cycle leave it unchanged
    // The host never pushes into a full queue while it honours its credits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_cnt <= '0;
        end else begin
            case ({cmd_valid, exec_pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Head decode
    // ------------------------------------------------------------

    assign dec_valid = (q_cnt != '0);
    assign head_op   = q_op[rd_ptr];
    assign dec_addr  = q_addr[rd_ptr];
    assign dec_data  = q_data[rd_ptr];

    // One-hot flags, all low when the queue is empty
    assign dec_write   = dec_valid && (head_op == `RF_OP_WRITE);
    assign dec_read    = dec_valid && (head_op == `RF_OP_READ);
    assign dec_add     = dec_valid && (head_op == `RF_OP_ADD);
    assign dec_illegal = dec_valid && !(dec_write || dec_read || dec_add);

    // One credit back to the host in the cycle after each pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_credit <= 1'b0;
        end else begin
            cmd_credit <= exec_pop;
        end
    end

endmodule

//--- rtl/rf_cmd_execute.sv
`timescale 1ns/1ps

module rf_cmd_execute import rf_store_pkg::*; (
     input  logic     clk
    ,input  logic     rst_n

    // Head of the command queue
    ,input  logic     dec_valid
    ,input  logic     dec_write
    ,input  logic     dec_read
    ,input  logic     dec_add
    ,input  logic     dec_illegal
    ,input  rf_addr_t dec_addr
    ,input  rf_data_t dec_data
    ,output logic     exec_pop

    // Result credit available
    ,input  logic     res_slot

    // Register file ports
    ,output logic     we
    ,output rf_addr_t waddr
    ,output rf_data_t wdata
    ,output logic     re
    ,output rf_addr_t raddr
    ,input  rf_data_t rdata

    // Result push towards the output stage
    ,output logic     res_push
    ,output rf_data_t res_push_data
    ,output logic     res_push_err
);

    exec_state_e state;
    exec_state_e state_nxt;

    // Set while the command in flight is an ADD
    logic        is_add_q;
    rf_addr_t    addr_q;
    rf_data_t    addend_q;
    rf_data_t    sum_q;
    rf_data_t    sum;

    logic        idle_write;
    logic        idle_illegal;
    logic        idle_rd_issue;

    // ------------------------------------------------------------
    // Issue decisions in IDLE
    // ------------------------------------------------------------

    // A WRITE needs no result credit, everything else waits for one
    assign idle_write    = (state == IDLE) && dec_write;
    assign idle_illegal  = (state == IDLE) && dec_illegal && res_slot;
    assign idle_rd_issue = (state == IDLE) && (dec_read || dec_add) && res_slot;

    assign exec_pop = dec_valid && (idle_write || idle_illegal || idle_rd_issue);

    // Sum wraps at the word width
    assign sum = rdata + addend_q;

    // ------------------------------------------------------------
    // Register file drive
    // ------------------------------------------------------------

    // The write port is shared by a plain WRITE and the ADD write back
    assign we    = idle_write || (state == WRITE_BACK);
    assign waddr = (state == WRITE_BACK) ? addr_q : dec_addr;
    assign wdata = (state == WRITE_BACK) ? sum_q : dec_data;

    assign re    = idle_rd_issue;
    assign raddr = dec_addr;

    // ------------------------------------------------------------
    // Result push
    // ------------------------------------------------------------

    // READ and ADD both report in READ_WAIT, so both reach the output
    // in the same cycle; the ADD store follows one cycle later
    assign res_push      = idle_illegal || (state == READ_WAIT);
    assign res_push_err  = idle_illegal;
    assign res_push_data = (state != READ_WAIT) ? '0 :
                           (is_add_q ? sum : rdata);

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (idle_rd_issue) state_nxt = READ_WAIT;
            READ_WAIT:  state_nxt = is_add_q ? WRITE_BACK : IDLE;
            WRITE_BACK: state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            is_add_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (idle_rd_issue) begin
                is_add_q <= dec_add;
            end
        end
    end

    // Operands of the command in flight
    always_ff @(posedge clk) begin
        if (idle_rd_issue) begin
            addr_q   <= dec_addr;
            addend_q <= dec_data;
        end
        if (state == READ_WAIT) begin
            sum_q <= sum;
        end
    end

endmodule

//--- rtl/rf_result_out.sv
`timescale 1ns/1ps
`include "rf_store_config.svh"

module rf_result_out import rf_store_pkg::*; (
     input  logic     clk
    ,input  logic     rst_n

    // Result push from execute
    ,input  logic     res_push
    ,input  rf_data_t res_push_data
    ,input  logic     res_push_err

    // Credit return from the host
    ,input  logic     res_credit

    // Credit available towards execute
    ,output logic     res_slot

    // Registered result towards the host
    ,output logic     res_valid
    ,output rf_data_t res_data
    ,output logic     res_err
);

    cred_cnt_t res_cnt;

    // ------------------------------------------------------------
    // Result credit counter
    // ------------------------------------------------------------

    // Starts full, one credit per push, one back per host return
    // A push and a return in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_cnt <= cred_cnt_t'(`RES_CREDITS);
        end else begin
            case ({res_push, res_credit})
                2'b10:   res_cnt <= res_cnt - 1'b1;
                2'b01:   res_cnt <= res_cnt + 1'b1;
                default: res_cnt <= res_cnt;
            endcase
        end
    end

    assign res_slot = (res_cnt != '0);

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------

    // Valid is a single-cycle pulse per push
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= res_push;
        end
    end

    // Data and error hold between pushes, only valid qualifies them
    always_ff @(posedge clk) begin
        if (res_push) begin
            res_data <= res_push_data;
            res_err  <= res_push_err;
        end
    end

endmodule

//--- rtl/rf_store_top.sv
`timescale 1ns/1ps

module rf_store_top import rf_store_pkg::*; (
     input  logic     clk
    ,input  logic     rst_n

    // Command side
    ,input  logic     cmd_valid
    ,input  rf_op_t   cmd_op
    ,input  rf_addr_t cmd_addr
    ,input  rf_data_t cmd_data
    ,output logic     cmd_credit

    // Result side
    ,input  logic     res_credit
    ,output logic     res_valid
    ,output rf_data_t res_data
    ,output logic     res_err
);

    // Queue head towards execute
    logic     dec_valid;
    logic     dec_write;
    logic     dec_read;
    logic     dec_add;
    logic     dec_illegal;
    rf_addr_t dec_addr;
    rf_data_t dec_data;
    logic     exec_pop;

    // Register file
    logic     we;
    rf_addr_t waddr;
    rf_data_t wdata;
    logic     re;
    rf_addr_t raddr;
    rf_data_t rdata;

    // Result path
    logic     res_slot;
    logic     res_push;
    rf_data_t res_push_data;
    logic     res_push_err;

    // ------------------------------------------------------------
    // Command queue and decode
    // ------------------------------------------------------------
    rf_cmd_decode dec_i (
         .clk         (clk)
        ,.rst_n       (rst_n)
        ,.cmd_valid   (cmd_valid)
        ,.cmd_op      (cmd_op)
        ,.cmd_addr    (cmd_addr)
        ,.cmd_data    (cmd_data)
        ,.cmd_credit  (cmd_credit)
        ,.dec_valid   (dec_valid)
        ,.dec_write   (dec_write)
        ,.dec_read    (dec_read)
        ,.dec_add     (dec_add)
        ,.dec_illegal (dec_illegal)
        ,.dec_addr    (dec_addr)
        ,.dec_data    (dec_data)
        ,.exec_pop    (exec_pop)
    );

    // ------------------------------------------------------------
    // Execute FSM
    // ------------------------------------------------------------
    rf_cmd_execute exec_i (
         .clk           (clk)
        ,.rst_n         (rst_n)
        ,.dec_valid     (dec_valid)
        ,.dec_write     (dec_write)
        ,.dec_read      (dec_read)
        ,.dec_add       (dec_add)
        ,.dec_illegal   (dec_illegal)
        ,.dec_addr      (dec_addr)
        ,.dec_data      (dec_data)
        ,.exec_pop      (exec_pop)
        ,.res_slot      (res_slot)
        ,.we            (we)
        ,.waddr         (waddr)
        ,.wdata         (wdata)
        ,.re            (re)
        ,.raddr         (raddr)
        ,.rdata         (rdata)
        ,.res_push      (res_push)
        ,.res_push_data (res_push_data)
        ,.res_push_err  (res_push_err)
    );

    // Storage, single clock for both ports
    rf_512x14 rf_i (
         .clk   (clk)
        ,.we    (we)
        ,.waddr (waddr)
        ,.wdata (wdata)
        ,.re    (re)
        ,.raddr (raddr)
        ,.rdata (rdata)
    );

    // ------------------------------------------------------------
    // Result credits and output register
    // ------------------------------------------------------------
    rf_result_out res_i (
         .clk           (clk)
        ,.rst_n         (rst_n)
        ,.res_push      (res_push)
        ,.res_push_data (res_push_data)
        ,.res_push_err  (res_push_err)
        ,.res_credit    (res_credit)
        ,.res_slot      (res_slot)
        ,.res_valid     (res_valid)
        ,.res_data      (res_data)
        ,.res_err       (res_err)
    );

endmodule

//--- verification/rf_store_tb.sv
`timescale 1ns/1ps
`include "rf_store_config.svh"

module rf_store_tb;

    localparam int WAIT_LIMIT = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_valid;
    logic [`RF_OP_W-1:0]   cmd_op;
    logic [`RF_ADDR_W-1:0] cmd_addr;
    logic [`RF_DATA_W-1:0] cmd_data;
    logic                  cmd_credit;
    logic                  res_credit;
    logic                  res_valid;
    logic [`RF_DATA_W-1:0] res_data;
    logic                  res_err;

    // Host side bookkeeping
    // The monitor counts on the rising edge and the senders read the counts on the falling edge
    int          cmd_sent = 0;
    int          cmd_returned = 0;
    int          res_seen = 0;
    int          res_returned = 0;
    int          errors = 0;
    int          test_id = 0;
    int          test_err_base = 0;
    int          test_cmds = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    bit          hold_res = 1'b0;
    integer      seed = 32'he7be_e8fc;
    // Expected result per command in issue order with the error flag on top
    logic [14:0] exp_q[$];
    logic [14:0] exp_now;

    rf_store_top dut_i (
         .clk        (clk)
        ,.rst_n      (rst_n)
        ,.cmd_valid  (cmd_valid)
        ,.cmd_op     (cmd_op)
        ,.cmd_addr   (cmd_addr)
        ,.cmd_data   (cmd_data)
        ,.cmd_credit (cmd_credit)
        ,.res_credit (res_credit)
        ,.res_valid  (res_valid)
        ,.res_data   (res_data)
        ,.res_err    (res_err)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ------------------------------------------------------------
    // Ending the run
    // ------------------------------------------------------------

    task automatic finish_run(input bit ok);
        if (ok) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout in test %0d: %s", test_id, what);
        errors++;
        finish_run(1'b0);
    endtask

    // ------------------------------------------------------------
    // Host command side
    // ------------------------------------------------------------

    // Waits for a command credit, then drives the command for one cycle
    task automatic send_cmd(input logic [`RF_OP_W-1:0] op, input logic [`RF_ADDR_W-1:0] addr,
                            input logic [`RF_DATA_W-1:0] data, input bit has_res,
                            input logic [14:0] exp);
        int waited;
        waited = 0;
        while (`CMD_CREDITS - cmd_sent + cmd_returned <= 0) begin
            if (waited >= WAIT_LIMIT) timeout_fail("no command credit came back");
            @(negedge clk);
            waited++;
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        cmd_sent++;
        test_cmds++;
        if (has_res) exp_q.push_back(exp);
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // Releases withheld credits, drains the DUT and reports the test
    task automatic end_test();
        int waited;
        int host;
        waited = 0;
        host   = `CMD_CREDITS - cmd_sent + cmd_returned;
        // With results withheld the queue fills up and no credit is left
        if (hold_res) begin
            if (host != 0) begin
                $display("ERR host_credits test %0d exp 0x0 got 0x%0h", test_id, host);
                errors++;
            end
            hold_res = 1'b0;
        end
        while (exp_q.size() != 0 || cmd_returned != cmd_sent || res_returned != res_seen) begin
            if (waited >= WAIT_LIMIT) timeout_fail("results or credits still outstanding");
            @(negedge clk);
            waited++;
        end
        if (errors == test_err_base) begin
            tests_passed++;
            $display("test %0d: ok, %0d commands", test_id, test_cmds);
        end else begin
            tests_failed++;
            $display("test %0d: FAILED, %0d errors", test_id, errors - test_err_base);
        end
    endtask

    // ------------------------------------------------------------
    // Result credit return
    // ------------------------------------------------------------

    // One credit goes back per consumed result after 0 to 5 idle cycles
    initial begin : credit_return
        int delay;
        res_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (!hold_res && (res_seen > res_returned)) begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                res_credit = 1'b1;
                @(negedge clk);
                res_credit = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Monitor and result checks
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (rst_n) begin
            if (cmd_credit) cmd_returned++;
            if (res_credit) res_returned++;
            if (res_valid) begin
                res_seen++;
                if (exp_q.size() == 0) begin
                    $display("Test %0d: a result arrived with no command waiting", test_id);
                    errors++;
                end else begin
                    exp_now = exp_q.pop_front();
                    if (res_err !== exp_now[14]) begin
                        $display("ERR res_err test %0d exp 0x%h got 0x%h",
                                 test_id, exp_now[14], res_err);
                        errors++;
                    end
                    if (res_data !== exp_now[13:0]) begin
                        $display("ERR res_data test %0d exp 0x%h got 0x%h",
                                 test_id, exp_now[13:0], res_data);
                        errors++;
                    end
                end
            end
            // More credits back than commands sent means a spurious pulse
            if (cmd_returned > cmd_sent) begin
                $display("Test %0d: more command credits came back than were sent", test_id);
                errors++;
            end
            if (res_seen - res_returned > `RES_CREDITS) begin
                $display("Test %0d: results arrived beyond the result credits held", test_id);
                errors++;
            end
        end
    end

    // ------------------------------------------------------------
    // Main sequence driven from the cases file
    // ------------------------------------------------------------

    initial begin : main
        int                    fd;
        int                    n;
        int                    t;
        int                    h;
        int                    e_err;
        int                    e_dat;
        string                 line;
        string                 err_s;
        string                 res_s;
        logic [`RF_OP_W-1:0]   op;
        logic [`RF_ADDR_W-1:0] addr;
        logic [`RF_DATA_W-1:0] data;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = '0;
        cmd_addr  = '0;
        cmd_data  = '0;
        test_id   = -1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("verification/rf_store_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the cases file");
            errors++;
            finish_run(1'b0);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%d %d %h %h %h %s %s", t, h, op, addr, data, err_s, res_s);
                if (n != 7) begin
                    $display("Malformed line in cases file: %s", line);
                    errors++;
                    continue;
                end
                // A new test id closes the previous test first
                if (t != test_id) begin
                    if (test_id >= 0) end_test();
                    test_id       = t;
                    test_err_base = errors;
                    test_cmds     = 0;
                    hold_res      = (h != 0);
                end
                if (err_s == "-") begin
                    send_cmd(op, addr, data, 1'b0, '0);
                end else begin
                    e_err = err_s.atohex();
                    e_dat = res_s.atohex();
                    send_cmd(op, addr, data, 1'b1, {e_err[0], e_dat[13:0]});
                end
            end
            if (test_id >= 0) end_test();
            $fclose(fd);
            $display("tests: %0d ok, %0d failed, %0d errors", tests_passed, tests_failed, errors);
            finish_run(errors == 0 && tests_failed == 0);
        end
    end

endmodule

//--- verification/rf_store_cases.txt
# test hold op addr data exp_err exp_data (hex), "-" where no result comes back
# op 0 WRITE, 1 READ, 2 ADD, 3 illegal; hold 1 withholds result credits until sent
1 0 0 005 0abc - -
1 0 1 005 0000 0 0abc
1 0 0 1ff 3fff - -
1 0 0 080 1234 - -
1 0 1 1ff 0000 0 3fff
1 0 1 080 0000 0 1234
2 0 2 005 0001 0 0abd
2 0 1 005 0000 0 0abd
2 0 2 1ff 0003 0 0002
2 0 1 1ff 0000 0 0002
3 0 3 080 2222 1 0000
3 0 1 080 0000 0 1234
4 1 1 005 0000 0 0abd
4 1 1 1ff 0000 0 0002
4 1 1 080 0000 0 1234
4 1 1 005 0000 0 0abd
4 1 1 1ff 0000 0 0002
4 1 1 080 0000 0 1234
5 1 2 080 0001 0 1235
5 1 1 080 0000 0 1235
5 1 3 000 0000 1 0000
5 1 2 005 3000 0 3abd
5 1 2 005 0543 0 0000
5 1 1 005 0000 0 0000
6 0 0 100 0007 - -
6 0 2 100 0009 0 0010
6 0 1 100 0000 0 0010
6 0 2 100 3ff0 0 0000
6 0 1 100 0000 0 0000

//--- all.f
+incdir+rtl
rtl/rf_store_pkg.sv
rtl/rf_512x14.sv
rtl/rf_cmd_decode.sv
rtl/rf_cmd_execute.sv
rtl/rf_result_out.sv
rtl/rf_store_top.sv
verification/rf_store_tb.sv

//--- Bender.yml
package:
  name: rf_store

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rf_store_pkg.sv
      - rtl/rf_512x14.sv
      - rtl/rf_cmd_decode.sv
      - rtl/rf_cmd_execute.sv
      - rtl/rf_result_out.sv
      - rtl/rf_store_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/rf_store_tb.sv
